/* rtl/core_pkg.sv */
package core_pkg;

//----------------------------------------------------------------------
// Widths and fetch front end sizing
//----------------------------------------------------------------------
localparam int XLEN            = 32;
localparam int IMEM_AWIDTH     = XLEN;
localparam int IMEM_DWIDTH     = XLEN;

localparam logic [XLEN-1:0] CORE_BOOT_ADDR = 32'h0000_0200;   // First fetch after reset

localparam int RST_SYNC_STAGES = 2;     // Core reset release to qualifier
localparam int IQ_DEPTH        = 4;
localparam int IQ_CNT_W        = 3;     // Holds 0..IQ_DEPTH
localparam int IQ_PTR_W        = $clog2(IQ_DEPTH);

//----------------------------------------------------------------------
// Memory interface encodings
//----------------------------------------------------------------------
typedef enum logic {
    MEM_CMD_RD = 1'b0,
    MEM_CMD_WR = 1'b1
} mem_cmd_e;

// Response phase, IDLE means no response this cycle
typedef enum logic [1:0] {
    MEM_RESP_IDLE   = 2'b00,
    MEM_RESP_RDY_OK = 2'b01,
    MEM_RESP_RDY_ER = 2'b10
} mem_resp_e;

//----------------------------------------------------------------------
// Bundles
//----------------------------------------------------------------------
typedef struct packed {
    logic                   req;
    mem_cmd_e               cmd;
    logic [IMEM_AWIDTH-1:0] addr;
} imem_req_s;

typedef struct packed {
    logic                   req_ack;
    logic [IMEM_DWIDTH-1:0] rdata;
    mem_resp_e              resp;
} imem_resp_s;

// Single cycle pulse from the branch side
typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
} fetch_redirect_s;

typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic            err;       // Bus error on this fetch
} instr_s;

endpackage : core_pkg

/* rtl/core_reset_ctrl.sv */
`timescale 1ns/10ps

module core_reset_ctrl import core_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,           // Regular reset
    input  logic cpu_rst_n_i,       // CPU reset
    output logic core_rst_n_o,
    output logic core_rdc_qlfy_o
);

//----------------------------------------------------------------------
// Local signals
//----------------------------------------------------------------------
logic                       rst_n_in;
logic [RST_SYNC_STAGES-1:0] qlfy_sync_q;

// Both sources are synchronous to clk_i
assign rst_n_in = rst_n_i & cpu_rst_n_i;

//----------------------------------------------------------------------
// Core reset register
//----------------------------------------------------------------------
always_ff @(posedge clk_i) begin
    core_rst_n_o <= rst_n_in;
end

//----------------------------------------------------------------------
// Qualifier delay chain
//----------------------------------------------------------------------
// Cleared from the raw inputs so it falls on the same edge as core_rst_n_o
always_ff @(posedge clk_i) begin
    if (!rst_n_in) begin
        qlfy_sync_q <= '0;
    end else begin
        qlfy_sync_q[0] <= core_rst_n_o;
        for (int i = 1; i < RST_SYNC_STAGES; i++) begin
            qlfy_sync_q[i] <= qlfy_sync_q[i-1];
        end
    end
end

assign core_rdc_qlfy_o = qlfy_sync_q[RST_SYNC_STAGES-1];

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
a_qlfy_in_rst: assert property (@(posedge clk_i)
    !core_rst_n_o |-> !core_rdc_qlfy_o)
    else $error("RDC qualifier high while core reset is active");

endmodule : core_reset_ctrl

/* rtl/ifu_fetch_ctrl.sv */
`timescale 1ns/10ps

module ifu_fetch_ctrl import core_pkg::*; (
    input  logic                clk_i,
    input  logic                core_rst_n_i,
    input  logic                rdc_qlfy_i,
    // Instruction memory
    output imem_req_s           imem_req_o,
    input  imem_resp_s          imem_resp_i,
    // Redirect from the branch side
    input  fetch_redirect_s     redirect_i,
    // Instruction queue
    input  logic [IQ_CNT_W-1:0] iq_cnt_i,
    output logic                iq_push_o,
    output logic                iq_flush_o,
    output instr_s              iq_data_o
);

//----------------------------------------------------------------------
// Local signals
//----------------------------------------------------------------------
logic                   fetch_en_q;
logic [XLEN-1:0]        fetch_addr_q;
logic [IQ_CNT_W-1:0]    inflight_q;     // Requests whose data is wanted
logic [IQ_CNT_W-1:0]    discard_q;      // Requests issued before a redirect
logic [IQ_CNT_W+1:0]    occupancy;

logic [XLEN-1:0]        pc_fifo [IQ_DEPTH];
logic [IQ_PTR_W-1:0]    pc_wr_ptr_q;
logic [IQ_PTR_W-1:0]    pc_rd_ptr_q;

logic                   req_acc;
logic                   resp_vld;
logic                   resp_drop;
logic                   resp_take;

//----------------------------------------------------------------------
// Request side
//----------------------------------------------------------------------
// Outstanding plus queued never exceeds the queue depth
assign occupancy = (IQ_CNT_W+2)'(inflight_q) + (IQ_CNT_W+2)'(discard_q)
                 + (IQ_CNT_W+2)'(iq_cnt_i);

always_comb begin
    imem_req_o.req  = fetch_en_q & (occupancy < (IQ_CNT_W+2)'(IQ_DEPTH));
    imem_req_o.cmd  = MEM_CMD_RD;
    imem_req_o.addr = fetch_addr_q;
end

assign req_acc   = imem_req_o.req & imem_resp_i.req_ack;
assign resp_vld  = (imem_resp_i.resp != MEM_RESP_IDLE);
assign resp_drop = resp_vld & (discard_q != '0);
assign resp_take = resp_vld & (discard_q == '0);

always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
        fetch_en_q   <= 1'b0;
        fetch_addr_q <= CORE_BOOT_ADDR;
    end else begin
        fetch_en_q <= rdc_qlfy_i;           // One cycle after the qualifier
        if (redirect_i.valid) begin
            fetch_addr_q <= redirect_i.target;
        end else if (req_acc) begin
            fetch_addr_q <= fetch_addr_q + XLEN'(4);
        end
    end
end

//----------------------------------------------------------------------
// Outstanding request tracking
//----------------------------------------------------------------------
always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
        inflight_q <= '0;
        discard_q  <= '0;
    end else if (redirect_i.valid) begin
        // Everything in flight, including a request taken now, is stale
        inflight_q <= '0;
        discard_q  <= discard_q + inflight_q + IQ_CNT_W'(req_acc)
                    - IQ_CNT_W'(resp_vld);
    end else begin
        inflight_q <= inflight_q + IQ_CNT_W'(req_acc) - IQ_CNT_W'(resp_take);
        discard_q  <= discard_q - IQ_CNT_W'(resp_drop);
    end
end

// Addresses of wanted requests, oldest at the read pointer
always_ff @(posedge clk_i) begin
    if (!core_rst_n_i || redirect_i.valid) begin
        pc_wr_ptr_q <= '0;
        pc_rd_ptr_q <= '0;
    end else begin
        if (req_acc) begin
            pc_wr_ptr_q <= pc_wr_ptr_q + IQ_PTR_W'(1);
        end
        if (resp_take) begin
            pc_rd_ptr_q <= pc_rd_ptr_q + IQ_PTR_W'(1);
        end
    end
end

always_ff @(posedge clk_i) begin
    if (req_acc) begin
        pc_fifo[pc_wr_ptr_q] <= fetch_addr_q;
    end
end

//----------------------------------------------------------------------
// Queue side
//----------------------------------------------------------------------
assign iq_push_o  = resp_take & ~redirect_i.valid;
assign iq_flush_o = redirect_i.valid;

always_comb begin
    iq_data_o.pc    = pc_fifo[pc_rd_ptr_q];
    iq_data_o.instr = imem_resp_i.rdata;
    iq_data_o.err   = (imem_resp_i.resp == MEM_RESP_RDY_ER);
end

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
a_resp_expected: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    resp_vld |-> (inflight_q != '0) || (discard_q != '0))
    else $error("IMEM response with no request outstanding");

a_addr_hold: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    (imem_req_o.req && !imem_resp_i.req_ack && !redirect_i.valid)
    |=> imem_req_o.req && $stable(imem_req_o.addr))
    else $error("IMEM request dropped or address changed before acknowledge");

endmodule : ifu_fetch_ctrl

/* rtl/ifu_instr_queue.sv */
`timescale 1ns/10ps

module ifu_instr_queue import core_pkg::*; (
    input  logic                clk_i,
    input  logic                core_rst_n_i,
    input  logic                push_i,
    input  logic                flush_i,
    input  instr_s              data_i,
    output logic [IQ_CNT_W-1:0] cnt_o,
    output instr_s              out_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

//----------------------------------------------------------------------
// Storage and pointers
//----------------------------------------------------------------------
instr_s                 mem [IQ_DEPTH];
logic [IQ_PTR_W-1:0]    wr_ptr_q;
logic [IQ_PTR_W-1:0]    rd_ptr_q;
logic [IQ_CNT_W-1:0]    cnt_q;
logic                   pop;

assign pop         = out_valid_o & out_ready_i;
assign out_valid_o = (cnt_q != '0);
assign out_o       = mem[rd_ptr_q];     // Head entry
assign cnt_o       = cnt_q;

always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
    end else if (flush_i) begin
        // Redirect drops all queued words
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
    end else begin
        if (push_i) begin
            wr_ptr_q <= wr_ptr_q + IQ_PTR_W'(1);
        end
        if (pop) begin
            rd_ptr_q <= rd_ptr_q + IQ_PTR_W'(1);
        end
        cnt_q <= cnt_q + IQ_CNT_W'(push_i) - IQ_CNT_W'(pop);
    end
end

always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
        mem[wr_ptr_q] <= data_i;
    end
end

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
// Fetch side reserves a slot for every request it issues
a_no_overflow: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    push_i |-> cnt_q != IQ_CNT_W'(IQ_DEPTH))
    else $error("Push into a full instruction queue");

a_out_hold: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> out_valid_o && $stable(out_o))
    else $error("Queue output changed while stalled");

endmodule : ifu_instr_queue

/* rtl/core_top.sv */
`timescale 1ns/10ps

module core_top import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,            // Regular reset
    input  logic            cpu_rst_n_i,        // CPU reset
    output logic            core_rst_n_o,
    output logic            core_rdc_qlfy_o,
    // Instruction memory
    output imem_req_s       imem_req_o,
    input  imem_resp_s      imem_resp_i,
    // Fetch redirect
    input  fetch_redirect_s redirect_i,
    // Instruction stream out
    output instr_s          instr_o,
    output logic            instr_valid_o,
    input  logic            instr_ready_i
);

//----------------------------------------------------------------------
// Local signals
//----------------------------------------------------------------------
logic                   iq_push;
logic                   iq_flush;
instr_s                 iq_data;
logic [IQ_CNT_W-1:0]    iq_cnt;

//----------------------------------------------------------------------
// Reset control
//----------------------------------------------------------------------
core_reset_ctrl i_reset_ctrl (
    .clk_i              (clk_i          ),
    .rst_n_i            (rst_n_i        ),
    .cpu_rst_n_i        (cpu_rst_n_i    ),
    .core_rst_n_o       (core_rst_n_o   ),
    .core_rdc_qlfy_o    (core_rdc_qlfy_o)
);

//----------------------------------------------------------------------
// Fetch front end
//----------------------------------------------------------------------
ifu_fetch_ctrl i_fetch_ctrl (
    .clk_i              (clk_i          ),
    .core_rst_n_i       (core_rst_n_o   ),
    .rdc_qlfy_i         (core_rdc_qlfy_o),
    .imem_req_o         (imem_req_o     ),
    .imem_resp_i        (imem_resp_i    ),
    .redirect_i         (redirect_i     ),
    .iq_cnt_i           (iq_cnt         ),
    .iq_push_o          (iq_push        ),
    .iq_flush_o         (iq_flush       ),
    .iq_data_o          (iq_data        )
);

ifu_instr_queue i_instr_queue (
    .clk_i              (clk_i          ),
    .core_rst_n_i       (core_rst_n_o   ),
    .push_i             (iq_push        ),
    .flush_i            (iq_flush       ),
    .data_i             (iq_data        ),
    .cnt_o              (iq_cnt         ),
    .out_o              (instr_o        ),
    .out_valid_o        (instr_valid_o  ),
    .out_ready_i        (instr_ready_i  )
);

endmodule : core_top

/* tb/core_checker.sv */
`timescale 1ns/10ps

module core_checker import core_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       cpu_rst_n_i,
    input  logic       core_rst_n_i,
    input  logic       qlfy_i,
    input  imem_req_s  imem_req_i,
    input  imem_resp_s imem_resp_i,
    input  instr_s     instr_i,
    input  logic       valid_i,
    input  logic       ready_i
);

instr_s exp_q[$];
string  cur_name;
int     delivered;
int     test_errs;
int     pass_cnt;
int     fail_cnt;

// Reset tracking
bit     seen;
logic   in_q;           // Combined reset inputs at the previous edge
int     run_cnt;        // Consecutive cycles with core reset released
logic   prev_qlfy;
int     outstanding;

initial begin
    delivered   = 0;
    test_errs   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    seen        = 1'b0;
    in_q        = 1'b0;
    run_cnt     = 0;
    prev_qlfy   = 1'b0;
    outstanding = 0;
end

task automatic start_test(input string name);
    cur_name  = name;
    delivered = 0;
    exp_q.delete();
endtask

task automatic expect_instr(input logic [31:0] pc, input logic err);
    instr_s item;
    item.pc    = pc;
    item.instr = ~pc;
    item.err   = err;
    exp_q.push_back(item);
endtask

task automatic finish_test();
    if (exp_q.size() != 0) begin
        $display("Test %s is missing %0d instructions", cur_name, exp_q.size());
        test_errs++;
    end
    if (test_errs == 0) begin
        $display("Test %s: PASS (%0d instructions)", cur_name, delivered);
        pass_cnt++;
    end else begin
        $display("Test %s: FAIL (%0d errors)", cur_name, test_errs);
        fail_cnt++;
    end
    test_errs = 0;
endtask

task automatic report();
    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
endtask

//----------------------------------------------------------------------
// Reset and request timing
//----------------------------------------------------------------------
always @(posedge clk_i) begin
    if (seen && core_rst_n_i !== in_q) begin
        $display("Mismatch at %0t: core reset %b, expected %b", $time, core_rst_n_i, in_q);
        test_errs++;
    end
    run_cnt = (core_rst_n_i === 1'b1) ? run_cnt + 1 : 0;
    if (seen && qlfy_i !== (run_cnt > RST_SYNC_STAGES)) begin
        $display("Mismatch at %0t: qualifier %b after %0d released cycles", $time, qlfy_i,
                 run_cnt);
        test_errs++;
    end
    if (imem_req_i.req === 1'b1 && prev_qlfy !== 1'b1) begin
        $display("Mismatch at %0t: request issued before the qualifier", $time);
        test_errs++;
    end
    if (imem_req_i.req === 1'b1 && imem_req_i.cmd !== MEM_CMD_RD) begin
        $display("Mismatch at %0t: request command %b is not a read", $time,
                 imem_req_i.cmd);
        test_errs++;
    end
    // Outstanding requests are bounded by the queue depth
    if (core_rst_n_i !== 1'b1) begin
        outstanding = 0;
    end else begin
        outstanding += int'(imem_req_i.req && imem_resp_i.req_ack);
        outstanding -= int'(imem_resp_i.resp != MEM_RESP_IDLE);
        if (outstanding > IQ_DEPTH) begin
            $display("Mismatch at %0t: %0d requests outstanding", $time, outstanding);
            test_errs++;
        end
    end
    prev_qlfy = qlfy_i;
    in_q      = rst_n_i & cpu_rst_n_i;
    seen      = 1'b1;
end

//----------------------------------------------------------------------
// Instruction stream
//----------------------------------------------------------------------
always @(posedge clk_i) begin
    instr_s exp;
    if (valid_i === 1'b1 && ready_i === 1'b1) begin
        if (exp_q.size() == 0) begin
            $display("Mismatch at %0t: unexpected instruction at pc %h", $time, instr_i.pc);
            test_errs++;
        end else begin
            exp = exp_q.pop_front();
            if (instr_i !== exp) begin
                $display("Mismatch at %0t: got pc %h instr %h err %b, expected %h %h %b",
                         $time, instr_i.pc, instr_i.instr, instr_i.err,
                         exp.pc, exp.instr, exp.err);
                test_errs++;
            end
        end
        delivered++;
    end
end

endmodule : core_checker

/* tb/tb_core_top.sv */
`timescale 1ns/10ps

module tb_core_top import core_pkg::*; ();

localparam string GOLDEN_FILE = "tb/core_golden.txt";
localparam int    CLK_PERIOD  = 100;
localparam int    RST_CYCLES  = 16;

logic            clk_i;
logic            rst_n_i;
logic            cpu_rst_n_i;
logic            core_rst_n_o;
logic            core_rdc_qlfy_o;
imem_req_s       imem_req_o;
imem_resp_s      imem_resp_i;
fetch_redirect_s redirect_i;
instr_s          instr_o;
logic            instr_valid_o;
logic            instr_ready_i;

// Current test data from the golden file
int          ev_kind[$];        // 0 redirect, 1 CPU reset
int          ev_cnt[$];         // Delivered count that triggers the event
logic [31:0] ev_tgt[$];
logic [31:0] err_addrs[$];
logic [31:0] exp_pc[$];
int          total_pc;

// Memory model state
logic [31:0] pend_addr[$];
int          pend_due[$];
int          cyc;
bit          resp_now;

core_top dut (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .cpu_rst_n_i     (cpu_rst_n_i    ),
    .core_rst_n_o    (core_rst_n_o   ),
    .core_rdc_qlfy_o (core_rdc_qlfy_o),
    .imem_req_o      (imem_req_o     ),
    .imem_resp_i     (imem_resp_i    ),
    .redirect_i      (redirect_i     ),
    .instr_o         (instr_o        ),
    .instr_valid_o   (instr_valid_o  ),
    .instr_ready_i   (instr_ready_i  )
);

core_checker u_checker (
    .clk_i       (clk_i          ),
    .rst_n_i     (rst_n_i        ),
    .cpu_rst_n_i (cpu_rst_n_i    ),
    .core_rst_n_i(core_rst_n_o   ),
    .qlfy_i      (core_rdc_qlfy_o),
    .imem_req_i  (imem_req_o     ),
    .imem_resp_i (imem_resp_i    ),
    .instr_i     (instr_o        ),
    .valid_i     (instr_valid_o  ),
    .ready_i     (instr_ready_i  )
);

initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
end

function automatic bit is_err_addr(input logic [31:0] addr);
    foreach (err_addrs[i]) begin
        if (err_addrs[i] == addr) return 1'b1;
    end
    return 1'b0;
endfunction

//----------------------------------------------------------------------
// Instruction memory model
//----------------------------------------------------------------------
always @(posedge clk_i) begin
    cyc++;
    if (core_rst_n_o !== 1'b1) begin
        pend_addr.delete();   // Core reset drops all outstanding requests
        pend_due.delete();
    end else begin
        if (resp_now) begin
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        if (imem_req_o.req && imem_resp_i.req_ack) begin
            pend_addr.push_back(imem_req_o.addr);
            pend_due.push_back(cyc + 1 + int'($urandom % 4));
        end
    end
end

always @(negedge clk_i) begin
    imem_resp_i.req_ack = ($urandom % 4) != 0;
    if (pend_addr.size() != 0 && cyc >= pend_due[0]) begin
        resp_now          = 1'b1;
        imem_resp_i.rdata = ~pend_addr[0];
        imem_resp_i.resp  = is_err_addr(pend_addr[0]) ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
    end else begin
        resp_now          = 1'b0;
        imem_resp_i.rdata = '0;
        imem_resp_i.resp  = MEM_RESP_IDLE;
    end
end

//----------------------------------------------------------------------
// Test sequencing
//----------------------------------------------------------------------
task automatic run_test(input string name, input int pct);
    int ev;
    ev = 0;
    u_checker.start_test(name);
    foreach (exp_pc[i]) u_checker.expect_instr(exp_pc[i], is_err_addr(exp_pc[i]));
    forever begin
        @(negedge clk_i);
        redirect_i = '0;
        if (ev < ev_kind.size() && ev_cnt[ev] == u_checker.delivered) begin
            instr_ready_i = 1'b0;               // Hold the stream at the event point
            if (ev_kind[ev] == 0) begin
                redirect_i = {1'b1, ev_tgt[ev]};
            end else begin
                cpu_rst_n_i = 1'b0;
                repeat (3) @(negedge clk_i);
                cpu_rst_n_i = 1'b1;
            end
            ev++;
        end else if (u_checker.delivered >= exp_pc.size()) begin
            instr_ready_i = 1'b0;
            break;
        end else begin
            instr_ready_i = int'($urandom % 100) < pct;
        end
    end
    u_checker.finish_test();
endtask

initial begin
    string       line;
    string       kw;
    string       tname;
    int          fd;
    int          n;
    int          pct;
    int          cnt;
    logic [31:0] addr;

    void'($urandom(32'ha3f7));
    rst_n_i       = 1'b0;
    cpu_rst_n_i   = 1'b1;
    redirect_i    = '0;
    instr_ready_i = 1'b0;
    imem_resp_i   = '0;
    resp_now      = 1'b0;
    cyc           = 0;
    total_pc      = 0;
    pct           = 100;

    // First pass sizes the watchdog
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
        $display("Cannot open golden file %s", GOLDEN_FILE);
        $display("Verification failed");
        $finish;
    end else begin
        while ($fgets(line, fd)) begin
            n = $sscanf(line, "%s", kw);
            if (n == 1 && kw == "pc") total_pc++;
        end
        $fclose(fd);

        repeat (RST_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;

        fd = $fopen(GOLDEN_FILE, "r");
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s", kw);
            case (kw)
                "test": begin
                    n = $sscanf(line, "%s %s %d", kw, tname, pct);
                    ev_kind.delete();
                    ev_cnt.delete();
                    ev_tgt.delete();
                    err_addrs.delete();
                    exp_pc.delete();
                end
                "redir": begin
                    n = $sscanf(line, "%s %d %h", kw, cnt, addr);
                    ev_kind.push_back(0);
                    ev_cnt.push_back(cnt);
                    ev_tgt.push_back(addr);
                end
                "cpurst": begin
                    n = $sscanf(line, "%s %d", kw, cnt);
                    ev_kind.push_back(1);
                    ev_cnt.push_back(cnt);
                    ev_tgt.push_back('0);
                end
                "err": begin
                    n = $sscanf(line, "%s %h", kw, addr);
                    err_addrs.push_back(addr);
                end
                "pc": begin
                    n = $sscanf(line, "%s %h", kw, addr);
                    exp_pc.push_back(addr);
                end
                "end": run_test(tname, pct);
                default: ;
            endcase
        end
        $fclose(fd);

        u_checker.report();
        if (u_checker.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end
end

// Watchdog, 40 cycles per expected instruction plus the reset phase
initial begin
    int limit;
    #1;
    limit = total_pc * 40 + RST_CYCLES + 100;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the tests did not complete within %0d cycles", limit);
    $display("Verification failed");
    $finish;
end

endmodule : tb_core_top

/* tb/core_golden.txt */
# test <name> <ready percent>; redir <delivered count> <target hex>; cpurst <delivered count>
# err <address hex>; pc <expected pc hex>; end runs the test
test boot_seq 100
pc 00000200
pc 00000204
pc 00000208
pc 0000020c
pc 00000210
pc 00000214
end
test backpressure 15
pc 00000218
pc 0000021c
pc 00000220
pc 00000224
pc 00000228
pc 0000022c
pc 00000230
pc 00000234
end
test redirect 70
redir 0 00001000
redir 3 00002000
pc 00001000
pc 00001004
pc 00001008
pc 00002000
pc 00002004
pc 00002008
end
test error_resp 60
redir 0 00003000
err 00003008
pc 00003000
pc 00003004
pc 00003008
pc 0000300c
pc 00003010
end
test cpu_reset 80
redir 0 00004000
cpurst 3
pc 00004000
pc 00004004
pc 00004008
pc 00000200
pc 00000204
pc 00000208
end

/* core_top.f */
rtl/core_pkg.sv
rtl/core_reset_ctrl.sv
rtl/ifu_fetch_ctrl.sv
rtl/ifu_instr_queue.sv
rtl/core_top.sv
tb/core_checker.sv
tb/tb_core_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core_top -f core_top.f > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_core_top > sim.log 2>&1 \
    || echo "Simulator returned a nonzero status"

cat sim.log

grep -q "Verification failed" sim.log \
    && { echo "Simulation FAILED"; exit 1; }

grep -q "Verification passed" sim.log \
    && { echo "Simulation PASSED"; exit 0; } \
    || { echo "Simulation ended without a result"; exit 1; }
